// ==== bench/vdp_sva.sv ====
//**************************************************************************
// vdp assertions
// AXI response hold, known video outputs and blanking of the window
//**************************************************************************
`timescale 1ns/1ps

module vdp_sva
    import vdp_pkg::*;
(
    input logic       pxclk,
    input logic       reset,
    input axil_req_t  axil_req,
    input axil_rsp_t  axil_rsp,
    input vga_sync_t  sync_out,
    input logic [3:0] color_out,
    input vdp_cfg_t   cfg
);

    bvalid_hold: assert property (@(posedge pxclk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge pxclk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    video_known: assert property (@(posedge pxclk) disable iff (reset)
        !$isunknown({sync_out, color_out}))
        else $error("unknown video output");

    // cfg must have settled through the colour stage
    blank_bg: assert property (@(posedge pxclk) disable iff (reset)
        cfg.blank && sync_out.vid_active && $past(cfg, 1) == cfg && $past(cfg, 2) == cfg
        |-> color_out == cfg.bg_color)
        else $error("blanked window pixel not bg colour");

endmodule

bind vdp_top vdp_sva u_sva (
    .pxclk     (pxclk),
    .reset     (reset),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .sync_out  (sync_out),
    .color_out (color_out),
    .cfg       (cfg)
);

// ==== bench/vdp_tb.sv ====
//**************************************************************************
// vdp testbench
// AXI4-Lite host, VRAM mirror with a graphics I reference model and a
// frame-by-frame comparator of raster structure and pixel colours
//**************************************************************************
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_tb
    import vdp_pkg::*;
;

    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;
    localparam int LOAD_CLKS = `VRAM_DEPTH * 3 + 500;
    localparam int LIMIT_NS = (8 * FRAME_CLKS + LOAD_CLKS) * 8;    // 7 frames of tests + slack

    logic       pxclk = 1'b0;
    logic       reset;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;
    vga_sync_t  sync_out;
    logic [3:0] color_out;

    logic [7:0] mirror [`VRAM_DEPTH];
    integer     seed;
    int         errors = 0;

    // configuration as the host last wrote it
    logic [3:0] cfg_name;
    logic [7:0] cfg_color;
    logic [2:0] cfg_pattern;
    logic [3:0] cfg_bg;
    logic       cfg_blank;

    // 0 no check, 1 rendered frame, 2 blanked frame
    int         req_mode = 0;
    int         frame_cnt = 0;

    vdp_top dut (
        .pxclk     (pxclk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .sync_out  (sync_out),
        .color_out (color_out)
    );

    always #4 pxclk = ~pxclk;

    initial begin
        #(LIMIT_NS);
        $display("timeout: the video frames did not complete in the expected time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "first mismatch");
        end
    endtask

    //**********************************************************************
    // AXI4-Lite host, requests driven on the falling edge
    //**********************************************************************
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
        @(negedge pxclk);
        axil_req.awaddr = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata = data;
        axil_req.wstrb = 4'hF;
        axil_req.wvalid = 1'b1;
        axil_req.bready = 1'b1;
        @(posedge pxclk);
        check_value(32'({axil_rsp.awready, axil_rsp.wready}), 32'd3, "awready and wready");
        @(negedge pxclk);
        while (!axil_rsp.bvalid)
            @(negedge pxclk);
        check_value(32'(axil_rsp.bresp), 32'd0, "bresp");
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        @(negedge pxclk);       // response taken at the edge before
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
        @(negedge pxclk);
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready = 1'b1;
        @(posedge pxclk);
        check_value(32'(axil_rsp.arready), 32'd1, "arready in idle");
        @(negedge pxclk);
        while (!axil_rsp.rvalid)
            @(negedge pxclk);
        data = axil_rsp.rdata;
        check_value(32'(axil_rsp.rresp), 32'd0, "rresp");
        axil_req.arvalid = 1'b0;
        @(negedge pxclk);
        axil_req.rready = 1'b0;
    endtask

    task automatic reg_roundtrip(input logic [4:0] addr, input logic [31:0] data,
                                 input logic [31:0] mask);
        logic [31:0] rd;
        axi_write(addr, data);
        axi_read(addr, rd);
        check_value(rd, data & mask, $sformatf("read-back of offset %0h", addr));
    endtask

    task automatic load_vram();
        axi_write(5'h14, 32'd0);
        for (int i = 0; i < `VRAM_DEPTH; i++) begin
            mirror[i] = 8'($random(seed));
            axi_write(5'h18, 32'(mirror[i]));
        end
    endtask

    // graphics I lookup of one 256x192 pixel
    function automatic logic [3:0] ref_pixel(input int x, input int y);
        logic [13:0] a;
        logic [7:0]  nm;
        logic [7:0]  pat;
        logic [7:0]  col;
        logic [3:0]  nib;
        a = 14'(int'(cfg_name) * 1024 + (y / 8) * 32 + x / 8);
        nm = mirror[a];
        a = 14'(int'(cfg_pattern) * 2048 + int'(nm) * 8 + y % 8);
        pat = mirror[a];
        a = 14'(int'(cfg_color) * 64 + int'(nm) / 8);
        col = mirror[a];
        nib = pat[7 - x % 8] ? col[7:4] : col[3:0];
        if (cfg_blank || nib == 4'd0)
            return cfg_bg;
        return nib;
    endfunction

    //**********************************************************************
    // comparator of raster structure and pixel colours
    //**********************************************************************
    localparam int LAST_LINE = `V_TOTAL - `V_VISIBLE - `V_FRONT - 1;    // counted from vsync

    logic vs_q = 1'b0;
    logic cl_q = 1'b0;
    bit   line_ok = 1'b0;
    int   mode_q = 0;
    int   line_clk = 0;
    int   lines = 0;
    int   xcnt = 0;
    int   ycnt = 0;
    int   bdr_cnt = 0;
    int   hs_cnt = 0;
    int   vs_cnt = 0;
    int   rl_cnt = 0;

    always @(posedge pxclk) begin
        if (sync_out.vsync && !vs_q) begin
            if (mode_q != 0) begin
                check_value(32'(lines), 32'd525, "lines per frame");
                check_value(32'(ycnt), 32'(`GFX_H), "graphic lines per frame");
                check_value(32'(bdr_cnt), 32'd110592, "border clocks per frame");
                check_value(32'(vs_cnt), 32'(`V_SYNC_LEN * `H_TOTAL), "vsync clocks per frame");
                check_value(32'(rl_cnt), 32'(`H_TOTAL), "row_last clocks per frame");
            end
            mode_q = req_mode;          // a frame is checked under one mode
            lines = 0;
            ycnt = 0;
            xcnt = 0;
            bdr_cnt = 0;
            vs_cnt = 0;
            rl_cnt = 0;
            frame_cnt++;
        end
        if (sync_out.col_last && !cl_q) begin
            if (mode_q != 0 && line_ok) begin
                check_value(32'(line_clk), 32'(`H_TOTAL), "clocks per line");
                check_value(32'(hs_cnt), 32'(`H_SYNC_LEN), "hsync clocks per line");
            end
            if (mode_q != 0) begin
                check_value(32'(sync_out.row_last), 32'(lines == LAST_LINE),
                            "row_last at line end");
                check_value(32'(sync_out.last_pixel), 32'(lines == LAST_LINE),
                            "last_pixel at line end");
            end
            if (xcnt != 0) begin
                if (mode_q != 0)
                    check_value(32'(xcnt), 32'(`GFX_W), "active clocks per line");
                ycnt++;
            end
            xcnt = 0;
            line_clk = 0;
            hs_cnt = 0;
            line_ok = 1'b1;
            lines++;
        end
        line_clk++;
        if (sync_out.hsync)
            hs_cnt++;
        if (sync_out.vsync)
            vs_cnt++;
        if (sync_out.row_last)
            rl_cnt++;

        if (mode_q != 0) begin
            check_value(32'(sync_out.last_pixel && !sync_out.col_last), 32'd0,
                        "last_pixel away from line end");
            check_value(32'((sync_out.hsync || sync_out.vsync)
                            && (sync_out.vid_active || sync_out.bdr_active)), 32'd0,
                        "sync pulse inside visible area");
        end

        if (sync_out.vid_active) begin
            if (mode_q != 0)
                check_value(32'(sync_out.bdr_active), 32'd0, "border inside window");
            if (mode_q == 1)
                check_value(32'(color_out), 32'(ref_pixel(xcnt / 2, ycnt / 2)),
                            $sformatf("pixel %0d,%0d", xcnt / 2, ycnt / 2));
            else if (mode_q == 2)
                check_value(32'(color_out), 32'(cfg_bg), "blanked pixel");
            xcnt++;
        end else if (sync_out.bdr_active) begin
            bdr_cnt++;
            if (mode_q != 0)
                check_value(32'(color_out), 32'(cfg_bg), "border colour");
        end else if (mode_q != 0) begin
            check_value(32'(color_out), 32'd0, "colour outside visible area");
        end
        vs_q = sync_out.vsync;
        cl_q = sync_out.col_last;
    end

    task automatic next_frame();
        int f;
        f = frame_cnt;
        wait (frame_cnt != f);
    endtask

    // mode is latched at one frame start and checked at the next
    task automatic run_frame(input int mode);
        req_mode = mode;
        next_frame();
        req_mode = 0;
        next_frame();
    endtask

    //**********************************************************************
    // test sequence
    //**********************************************************************
    initial begin
        logic [31:0] rd;
        axil_req = '0;
        reset = 1'b1;
        seed = 32'h8958;
        cfg_name = 4'h3;
        cfg_color = 8'h80;
        cfg_pattern = 3'h2;
        cfg_bg = 4'hA;
        cfg_blank = 1'b0;

        for (int i = 0; i < 4; i++) begin
            @(negedge pxclk);
            check_value(32'(sync_out), 32'd0, "sync_out in reset");
            check_value(32'(color_out), 32'd0, "color_out in reset");
            check_value(32'({axil_rsp.bvalid, axil_rsp.rvalid}), 32'd0, "valid in reset");
            check_value(32'({axil_rsp.awready, axil_rsp.wready}), 32'd0, "ready in reset");
        end
        reset = 1'b0;

        // register file
        reg_roundtrip(5'h00, 32'hFFFF_FFFF, 32'h0000_000F);
        reg_roundtrip(5'h04, 32'hFFFF_FFF6, 32'h0000_000F);
        reg_roundtrip(5'h08, 32'h1234_56C3, 32'h0000_00FF);
        reg_roundtrip(5'h0C, 32'hFFFF_FFFD, 32'h0000_0007);
        reg_roundtrip(5'h10, 32'hABCD_EF5A, 32'h0000_00FF);
        reg_roundtrip(5'h14, 32'hFFFF_F123, 32'h0000_3FFF);
        axi_read(5'h18, rd);
        check_value(rd, 32'd0, "read of vdata");
        axi_read(5'h1C, rd);
        check_value(rd, 32'd0, "read of unmapped offset");

        axi_write(5'h00, 32'h0);
        axi_write(5'h04, 32'(cfg_name));
        axi_write(5'h08, 32'(cfg_color));
        axi_write(5'h0C, 32'(cfg_pattern));
        axi_write(5'h10, 32'({4'h5, cfg_bg}));
        load_vram();

        next_frame();
        run_frame(1);

        axi_write(5'h00, 32'h8);        // blank on
        cfg_blank = 1'b1;
        run_frame(2);

        axi_write(5'h00, 32'h0);
        cfg_blank = 1'b0;
        run_frame(1);

        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/vdp_fsm.sv ====
//**************************************************************************
// graphics I renderer
// eight-slot fetch ring reading name, pattern and colour tables, a
// pattern shifter with colour select, and a sync delay of six steps
// so colour and sync leave together
//**************************************************************************
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_fsm
    import vdp_pkg::*;
(
    input  logic                pxclk,
    input  logic                reset,
    input  logic [9:0]          px_col,
    input  logic [9:0]          px_row,
    input  vga_sync_t           sync,
    input  vdp_cfg_t            cfg,
    output logic [`VRAM_AW-1:0] dma_addr,
    output logic                dma_rd,
    input  logic [7:0]          vram_dout,
    output vga_sync_t           sync_out,
    output logic [3:0]          color_out
);

    localparam int PIPE_LEN = 6;

    fetch_slot_e ring;
    vga_sync_t   sync_pipe [PIPE_LEN];      // [PIPE_LEN-1] is the newest
    logic        step;
    logic        line_start;
    logic [9:0]  tile_ctr;
    logic [9:0]  tile_row;                  // tile number at start of the row
    logic [9:0]  tile_idx;
    logic [7:0]  name_q;
    logic [7:0]  pattern_q;
    logic [7:0]  color_q;
    logic        pixel_q;                   // pattern bit, one step behind
    logic [3:0]  nibble;

    assign step = px_col[0];                // half rate, one graphic pixel

    // first tile of a window line, the previous step was outside
    assign line_start = sync.vid_active && !sync_pipe[PIPE_LEN-1].vid_active;

    // lines 1..15 of a tile row repeat the names of the row's first line
    assign tile_idx = (line_start && px_row[3:0] != 4'd0) ? tile_row : tile_ctr;

    assign nibble = pixel_q ? color_q[7:4] : color_q[3:0];

    //**********************************************************************
    // ring, tile counter, sync delay and colour stage
    //**********************************************************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            ring <= slot_name;
            dma_rd <= 1'b0;
            tile_ctr <= '0;
            tile_row <= '0;
            color_out <= 4'd0;
            for (int i = 0; i < PIPE_LEN; i++)
                sync_pipe[i] <= '0;
        end else begin
            dma_rd <= step && sync.vid_active
                   && (ring == slot_name || ring == slot_pattern || ring == slot_pat_lat);

            if (sync.vsync) begin
                tile_ctr <= '0;
                tile_row <= '0;
            end

            if (step) begin
                // 400 steps per line keep the ring in phase with the tiles
                ring <= fetch_slot_e'({ring[6:0], ring[7]});

                sync_pipe[PIPE_LEN-1] <= sync;
                for (int i = 0; i < PIPE_LEN - 1; i++)
                    sync_pipe[i] <= sync_pipe[i+1];

                // stage 1 holds the sync of the pixel now in pixel_q
                if (sync_pipe[1].vid_active)
                    color_out <= (cfg.blank || nibble == 4'd0) ? cfg.bg_color : nibble;
                else if (sync_pipe[1].bdr_active)
                    color_out <= cfg.bg_color;
                else
                    color_out <= 4'd0;

                if (sync.vid_active) begin
                    case (ring)
                        slot_name: begin
                            tile_ctr <= tile_idx;
                            if (line_start && px_row[3:0] == 4'd0)
                                tile_row <= tile_ctr;       // new tile row
                        end
                        slot_advance: tile_ctr <= tile_ctr + 1'b1;
                        default: ;      // cpu slots unused, host writes use port b
                    endcase
                end
            end
        end
    end

    //**********************************************************************
    // table fetch and pattern shifter
    //**********************************************************************
    always_ff @(posedge pxclk) begin
        if (step) begin
            pixel_q <= pattern_q[7];
            pattern_q <= {pattern_q[6:0], 1'b0};
            if (sync.vid_active) begin
                case (ring)
                    slot_name:     dma_addr <= {cfg.name_base, tile_idx};
                    slot_name_lat: name_q <= vram_dout;
                    slot_pattern:  dma_addr <= {cfg.pattern_base, name_q, px_row[3:1]};
                    slot_pat_lat: begin
                        pattern_q <= vram_dout;     // overrides the shift
                        dma_addr <= {cfg.color_base, 1'b0, name_q[7:3]};  // one byte per 8 names
                    end
                    slot_color_lat: color_q <= vram_dout;
                    default: ;
                endcase
            end
        end
    end

    assign sync_out = sync_pipe[0];

endmodule

// ==== hw/vdp_params.svh ====
//**************************************************************************
// vdp parameters
// raster timing of the 640x480 VGA frame, the doubled graphic window
// centred in it, VRAM size and the register bus address width
//**************************************************************************
`ifndef VDP_PARAMS_SVH
`define VDP_PARAMS_SVH

// horizontal raster, in pxclk periods
`define H_VISIBLE   640
`define H_FRONT     16
`define H_SYNC_LEN  96
`define H_TOTAL     800

// vertical raster, in lines
`define V_VISIBLE   480
`define V_FRONT     10
`define V_SYNC_LEN  2
`define V_TOTAL     525

// 256x192 graphic area, every pixel doubled in both directions
`define GFX_W       512
`define GFX_H       384
`define H_BORDER    64          // multiple of 16 keeps the fetch ring on tile edges
`define V_BORDER    48          // keep a multiple of 16

`define VRAM_AW     14
`define VRAM_DEPTH  (1 << `VRAM_AW)     // 16K bytes holds all three tables

`define AXIL_AW     5

`endif

// ==== hw/vdp_pkg.sv ====
//**************************************************************************
// vdp types
// configuration and sync bundles, AXI4-Lite request and response,
// register offsets and the state encodings
//**************************************************************************
`include "vdp_params.svh"

package vdp_pkg;

    typedef struct packed {
        logic [2:0] mode;           // stored only, graphics I is always drawn
        logic       blank;
        logic [3:0] name_base;      // name table at name_base * 1K
        logic [7:0] color_base;     // colour table at color_base * 64
        logic [2:0] pattern_base;   // pattern table at pattern_base * 2K
        logic [3:0] fg_color;
        logic [3:0] bg_color;       // transparent and border colour
    } vdp_cfg_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic vid_active;           // inside the graphic window
        logic bdr_active;           // visible but outside the window
        logic last_pixel;
        logic col_last;
        logic row_last;
    } vga_sync_t;

    typedef struct packed {
        logic [`AXIL_AW-1:0] awaddr;
        logic                awvalid;
        logic [31:0]         wdata;
        logic [3:0]          wstrb;
        logic                wvalid;
        logic                bready;
        logic [`AXIL_AW-1:0] araddr;
        logic                arvalid;
        logic                rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
        logic        arready;
    } axil_rsp_t;

    typedef enum logic [`AXIL_AW-1:0] {
        reg_ctrl    = `AXIL_AW'(8'h00),
        reg_name    = `AXIL_AW'(8'h04),
        reg_color   = `AXIL_AW'(8'h08),
        reg_pattern = `AXIL_AW'(8'h0C),
        reg_fgbg    = `AXIL_AW'(8'h10),
        reg_vaddr   = `AXIL_AW'(8'h14),
        reg_vdata   = `AXIL_AW'(8'h18)
    } reg_addr_e;

    // one-hot fetch ring, one slot per half-rate step
    typedef enum logic [7:0] {
        slot_name      = 8'b0000_0001,
        slot_name_lat  = 8'b0000_0010,
        slot_pattern   = 8'b0000_0100,
        slot_pat_lat   = 8'b0000_1000,
        slot_color_lat = 8'b0001_0000,
        slot_idle5     = 8'b0010_0000,
        slot_idle6     = 8'b0100_0000,
        slot_advance   = 8'b1000_0000
    } fetch_slot_e;

    typedef enum logic [1:0] {
        idle,
        write_resp,
        read_resp
    } axil_state_e;

endpackage

// ==== hw/vdp_regs_axil.sv ====
//**************************************************************************
// vdp register file
// AXI4-Lite slave holding the display configuration and a VRAM write
// pointer that steps by one on every data write
//**************************************************************************
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_regs_axil
    import vdp_pkg::*;
(
    input  logic                pxclk,
    input  logic                reset,
    input  axil_req_t           axil_req,
    output axil_rsp_t           axil_rsp,
    output vdp_cfg_t            cfg,
    output logic                vram_we,
    output logic [`VRAM_AW-1:0] vram_waddr,
    output logic [7:0]          vram_wdata
);

    axil_state_e         state;
    vdp_cfg_t            cfg_q;
    logic [`VRAM_AW-1:0] vaddr;            // auto-increment pointer
    logic [31:0]         rdata_q;
    logic [31:0]         rd_val;
    logic                rd_go;
    logic                wr_go;
    logic                wr_en;
    logic                vdata_wr;

    // a read wins over a write arriving in the same idle cycle
    assign rd_go = (state == idle) && axil_req.arvalid;
    assign wr_go = (state == idle) && axil_req.awvalid && axil_req.wvalid
                && !axil_req.arvalid;
    assign wr_en = wr_go && axil_req.wstrb[0];     // all fields sit in byte 0
    assign vdata_wr = wr_en && (reg_addr_e'(axil_req.awaddr) == reg_vdata);

    //**********************************************************************
    // bus state and register writes
    //**********************************************************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            state <= idle;
            cfg_q <= '0;
            vaddr <= '0;
            vram_we <= 1'b0;
        end else begin
            vram_we <= vdata_wr;
            unique case (state)
                idle: begin
                    if (rd_go)
                        state <= read_resp;
                    else if (wr_go)
                        state <= write_resp;
                end
                write_resp: if (axil_req.bready) state <= idle;
                read_resp:  if (axil_req.rready) state <= idle;
                default:    state <= idle;
            endcase

            if (wr_en) begin
                case (reg_addr_e'(axil_req.awaddr))
                    reg_ctrl: begin
                        cfg_q.mode <= axil_req.wdata[2:0];
                        cfg_q.blank <= axil_req.wdata[3];
                    end
                    reg_name:    cfg_q.name_base <= axil_req.wdata[3:0];
                    reg_color:   cfg_q.color_base <= axil_req.wdata[7:0];
                    reg_pattern: cfg_q.pattern_base <= axil_req.wdata[2:0];
                    reg_fgbg: begin
                        cfg_q.fg_color <= axil_req.wdata[7:4];
                        cfg_q.bg_color <= axil_req.wdata[3:0];
                    end
                    reg_vaddr:   vaddr <= axil_req.wdata[`VRAM_AW-1:0];
                    reg_vdata:   vaddr <= vaddr + 1'b1;
                    default: ;                      // unmapped, ignored
                endcase
            end
        end
    end

    // write data and read data registers
    always_ff @(posedge pxclk) begin
        if (vdata_wr) begin
            vram_waddr <= vaddr;
            vram_wdata <= axil_req.wdata[7:0];
        end
        if (rd_go)
            rdata_q <= rd_val;
    end

    //**********************************************************************
    // read mux and response channel
    //**********************************************************************
    always_comb begin
        case (reg_addr_e'(axil_req.araddr))
            reg_ctrl:    rd_val = 32'({cfg_q.blank, cfg_q.mode});
            reg_name:    rd_val = 32'(cfg_q.name_base);
            reg_color:   rd_val = 32'(cfg_q.color_base);
            reg_pattern: rd_val = 32'(cfg_q.pattern_base);
            reg_fgbg:    rd_val = 32'({cfg_q.fg_color, cfg_q.bg_color});
            reg_vaddr:   rd_val = 32'(vaddr);
            default:     rd_val = '0;               // vdata is write only
        endcase
    end

    always_comb begin
        axil_rsp.awready = wr_go;
        axil_rsp.wready = wr_go;
        axil_rsp.bresp = 2'b00;                     // OKAY
        axil_rsp.bvalid = (state == write_resp);
        axil_rsp.rdata = rdata_q;
        axil_rsp.rresp = 2'b00;
        axil_rsp.rvalid = (state == read_resp);
        axil_rsp.arready = (state == idle);
    end

    assign cfg = cfg_q;

endmodule

// ==== hw/vdp_top.sv ====
//**************************************************************************
// vdp top level
// register file, VRAM, raster timing and graphics I renderer
//**************************************************************************
`timescale 1ns/1ps
`include "vdp_params.svh"

module vdp_top
    import vdp_pkg::*;
(
    input  logic      pxclk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output vga_sync_t sync_out,
    output logic [3:0] color_out
);

    vdp_cfg_t            cfg;
    vga_sync_t           sync;
    logic [9:0]          px_col;
    logic [9:0]          px_row;
    logic                vram_we;
    logic [`VRAM_AW-1:0] vram_waddr;
    logic [7:0]          vram_wdata;
    logic [`VRAM_AW-1:0] dma_addr;
    logic                dma_rd;
    logic [7:0]          vram_dout;

    vga_timing u_timing (
        .pxclk      (pxclk),
        .reset      (reset),
        .px_col     (px_col),
        .px_row     (px_row),
        .sync       (sync)
    );

    vdp_regs_axil u_regs (
        .pxclk      (pxclk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .cfg        (cfg),
        .vram_we    (vram_we),
        .vram_waddr (vram_waddr),
        .vram_wdata (vram_wdata)
    );

    vram u_vram (
        .pxclk      (pxclk),
        .dma_addr   (dma_addr),
        .dma_rd     (dma_rd),
        .dout       (vram_dout),
        .we         (vram_we),
        .waddr      (vram_waddr),
        .wdata      (vram_wdata)
    );

    vdp_fsm u_fsm (
        .pxclk      (pxclk),
        .reset      (reset),
        .px_col     (px_col),
        .px_row     (px_row),
        .sync       (sync),
        .cfg        (cfg),
        .dma_addr   (dma_addr),
        .dma_rd     (dma_rd),
        .vram_dout  (vram_dout),
        .sync_out   (sync_out),
        .color_out  (color_out)
    );

endmodule

// ==== hw/vga_timing.sv ====
//**************************************************************************
// vga timing generator
// 800x525 raster counters, sync pulses, graphic window position and
// the area and raster-end flags used by the renderer
//**************************************************************************
`timescale 1ns/1ps
`include "vdp_params.svh"

module vga_timing
    import vdp_pkg::*;
(
    input  logic       pxclk,
    input  logic       reset,
    output logic [9:0] px_col,      // relative to the graphic window
    output logic [9:0] px_row,
    output vga_sync_t  sync
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_gfx;
    logic       v_gfx;
    logic       visible;

    always_ff @(posedge pxclk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (sync.col_last) begin
            h_cnt <= '0;
            if (sync.row_last)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // window position wraps negative in the borders
    assign px_col = h_cnt - 10'(`H_BORDER);
    assign px_row = v_cnt - 10'(`V_BORDER);

    assign h_gfx = (h_cnt >= 10'(`H_BORDER)) && (h_cnt < 10'(`H_BORDER + `GFX_W));
    assign v_gfx = (v_cnt >= 10'(`V_BORDER)) && (v_cnt < 10'(`V_BORDER + `GFX_H));
    assign visible = (h_cnt < 10'(`H_VISIBLE)) && (v_cnt < 10'(`V_VISIBLE));

    always_comb begin
        sync = '0;
        sync.hsync = (h_cnt >= 10'(`H_VISIBLE + `H_FRONT))
                  && (h_cnt < 10'(`H_VISIBLE + `H_FRONT + `H_SYNC_LEN));
        sync.vsync = (v_cnt >= 10'(`V_VISIBLE + `V_FRONT))
                  && (v_cnt < 10'(`V_VISIBLE + `V_FRONT + `V_SYNC_LEN));
        sync.vid_active = h_gfx && v_gfx;
        sync.bdr_active = visible && !(h_gfx && v_gfx);
        sync.col_last = (h_cnt == 10'(`H_TOTAL - 1));       // last clock of a line
        sync.row_last = (v_cnt == 10'(`V_TOTAL - 1));
        sync.last_pixel = sync.col_last && sync.row_last;   // end of frame
    end

endmodule

// ==== hw/vram.sv ====
//**************************************************************************
// video RAM
// 16K x 8, registered read port for the renderer and a write port
// for the host side
//**************************************************************************
`timescale 1ns/1ps
`include "vdp_params.svh"

module vram (
    input  logic                pxclk,
    input  logic [`VRAM_AW-1:0] dma_addr,
    input  logic                dma_rd,
    output logic [7:0]          dout,
    input  logic                we,
    input  logic [`VRAM_AW-1:0] waddr,
    input  logic [7:0]          wdata
);

    logic [7:0] mem [`VRAM_DEPTH];

    always_ff @(posedge pxclk) begin
        if (we)
            mem[waddr] <= wdata;
        if (dma_rd)
            dout <= mem[dma_addr];      // holds between reads
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vdp testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module vdp_tb -f tb.f -o vdp_sim \
    && ./obj_dir/vdp_sim | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" \
    && exit 0 \
    || exit 1

// ==== tb.f ====
+incdir+hw
hw/vdp_pkg.sv
hw/vga_timing.sv
hw/vdp_regs_axil.sv
hw/vram.sv
hw/vdp_fsm.sv
hw/vdp_top.sv
bench/vdp_sva.sv
bench/vdp_tb.sv
